/* common/lce_pkg.sv */
// sizes, opcodes, coherence states and message/memory packet types for the lce command handler
package lce_pkg;

  // cache geometry
  localparam int sets_c         = 8;
  localparam int lg_sets_c      = 3;
  localparam int assoc_c        = 2;
  localparam int lg_assoc_c     = 1;
  localparam int block_width_c  = 64;
  localparam int paddr_width_c  = 16;
  localparam int block_offset_c = 3;
  // tag is the top of the address, index sits just above the block offset
  localparam int tag_width_c    = 10;

  // system
  localparam int lce_id_width_c   = 2;
  localparam int num_cce_c        = 2;
  localparam int sync_cnt_width_c = 4;

  // inbound command opcodes from the CCE
  typedef enum logic [3:0] {
    e_cmd_sync      = 4'd0,
    e_cmd_set_clear = 4'd1,
    e_cmd_inv       = 4'd2,
    e_cmd_st        = 4'd3,
    e_cmd_data      = 4'd4,
    e_cmd_st_wakeup = 4'd5,
    e_cmd_wb        = 4'd6,
    e_cmd_st_wb     = 4'd7
  } lce_cmd_type_e;

  // outbound response opcodes
  typedef enum logic [2:0] {
    e_resp_sync_ack = 3'd0,
    e_resp_inv_ack  = 3'd1,
    e_resp_coh_ack  = 3'd2,
    e_resp_null_wb  = 3'd3,
    e_resp_wb       = 3'd4
  } lce_resp_type_e;

  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_f = 3'd3,
    e_coh_o = 3'd4,
    e_coh_m = 3'd5
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_set_clear = 2'd0,
    e_tag_set_state = 2'd1,
    e_tag_set_tag   = 2'd2
  } tag_mem_op_e;

  typedef enum logic [1:0] {
    e_stat_set_clear   = 2'd0,
    e_stat_read        = 2'd1,
    e_stat_clear_dirty = 2'd2
  } stat_mem_op_e;

  typedef enum logic {
    e_data_read  = 1'b0,
    e_data_write = 1'b1
  } data_mem_op_e;

  // whole block rides in a single beat
  typedef struct packed {
    lce_cmd_type_e              msg_type;
    logic [paddr_width_c-1:0]   addr;
    logic [lce_id_width_c-1:0]  src_id;
    logic [lg_assoc_c-1:0]      way_id;
    coh_state_e                 state;
    logic [block_width_c-1:0]   data;
  } lce_cmd_s;

  typedef struct packed {
    lce_resp_type_e             msg_type;
    logic [paddr_width_c-1:0]   addr;
    logic [lce_id_width_c-1:0]  src_id;
    logic [lce_id_width_c-1:0]  dst_id;
    logic [block_width_c-1:0]   data;
  } lce_resp_s;

  typedef struct packed {
    tag_mem_op_e             opcode;
    logic [lg_sets_c-1:0]    index;
    logic [lg_assoc_c-1:0]   way_id;
    coh_state_e              state;
    logic [tag_width_c-1:0]  tag;
  } tag_mem_pkt_s;

  typedef struct packed {
    stat_mem_op_e           opcode;
    logic [lg_sets_c-1:0]   index;
    logic [lg_assoc_c-1:0]  way_id;
  } stat_mem_pkt_s;

  typedef struct packed {
    data_mem_op_e              opcode;
    logic [lg_sets_c-1:0]      index;
    logic [lg_assoc_c-1:0]     way_id;
    logic [block_width_c-1:0]  data;
  } data_mem_pkt_s;

  // dirty bit per way of one set
  typedef struct packed {
    logic [assoc_c-1:0] dirty;
  } stat_info_s;

endpackage

/* lce_cmd.f */
+incdir+testbench
common/lce_pkg.sv
logic/lce_cmd_fifo.sv
lce_cmd_engine/lce_cmd_engine.sv
logic/lce_cmd.sv
testbench/lce_cmd_tb.sv

/* lce_cmd_engine/lce_cmd_engine.sv */
// command engine: reset clear sequencer, command FSM, sync counter and read capture
`timescale 1ns/1ns

module lce_cmd_engine
  import lce_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [lce_id_width_c-1:0]  lce_id_i,

  // head of the command queue
  input  lce_cmd_s                   cmd_i,
  input  logic                       cmd_v_i,
  output logic                       cmd_yumi_o,

  // response to the CCE
  output lce_resp_s                  lce_resp_o,
  output logic                       lce_resp_v_o,
  input  logic                       lce_resp_ready_i,

  // cache memory ports
  output tag_mem_pkt_s               tag_mem_pkt_o,
  output logic                       tag_mem_pkt_v_o,
  input  logic                       tag_mem_pkt_yumi_i,
  output stat_mem_pkt_s              stat_mem_pkt_o,
  output logic                       stat_mem_pkt_v_o,
  input  logic                       stat_mem_pkt_yumi_i,
  input  stat_info_s                 stat_mem_i,
  output data_mem_pkt_s              data_mem_pkt_o,
  output logic                       data_mem_pkt_v_o,
  input  logic                       data_mem_pkt_yumi_i,
  input  logic [block_width_c-1:0]   data_mem_i,

  output logic                       ready_o,
  output logic                       sync_done_o,
  output logic                       cache_req_complete_o
);

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_ready,
    e_coh_ack,
    e_wb,
    e_wb_dirty_rd,
    e_wb_dirty_send
  } engine_state_e;

  engine_state_e state_r;
  engine_state_e state_n;

  logic [lg_sets_c-1:0]        cmd_index;
  logic [tag_width_c-1:0]      cmd_tag;
  logic [sync_cnt_width_c-1:0] cnt_r;
  logic                        cnt_inc;
  logic                        cnt_clr;

  lce_resp_s                   resp_n;
  logic                        resp_load;
  logic                        resp_fire;
  logic                        sync_fire;

  logic                        stat_rd_fire;
  logic                        stat_rd_r;
  logic                        stat_v_r;
  stat_info_s                  stat_r;
  logic                        data_rd_fire;
  logic                        data_rd_r;
  logic                        data_v_r;
  logic [block_width_c-1:0]    data_r;

  assign cmd_index = cmd_i.addr[block_offset_c +: lg_sets_c];
  assign cmd_tag   = cmd_i.addr[paddr_width_c-1 -: tag_width_c];

  assign ready_o   = (state_r != e_reset) && (state_r != e_clear);
  assign resp_fire = lce_resp_v_o & lce_resp_ready_i;
  assign sync_fire = resp_fire & (lce_resp_o.msg_type == e_resp_sync_ack);

  // the cache request finishes when its coh_ack leaves
  assign cache_req_complete_o = resp_fire & (lce_resp_o.msg_type == e_resp_coh_ack);

  assign stat_rd_fire = stat_mem_pkt_v_o & stat_mem_pkt_yumi_i
                      & (stat_mem_pkt_o.opcode == e_stat_read);
  assign data_rd_fire = data_mem_pkt_v_o & data_mem_pkt_yumi_i
                      & (data_mem_pkt_o.opcode == e_data_read);

  always_comb begin
    state_n    = state_r;
    cmd_yumi_o = 1'b0;
    cnt_inc    = 1'b0;
    cnt_clr    = 1'b0;
    resp_load  = 1'b0;

    tag_mem_pkt_o    = '0;
    tag_mem_pkt_v_o  = 1'b0;
    stat_mem_pkt_o   = '0;
    stat_mem_pkt_v_o = 1'b0;
    data_mem_pkt_o   = '0;
    data_mem_pkt_v_o = 1'b0;

    // every response echoes the command address back to its sender
    resp_n          = '0;
    resp_n.addr     = cmd_i.addr;
    resp_n.src_id   = lce_id_i;
    resp_n.dst_id   = cmd_i.src_id;
    resp_n.msg_type = e_resp_sync_ack;

    // packet fields shared by most commands
    tag_mem_pkt_o.index   = cmd_index;
    tag_mem_pkt_o.way_id  = cmd_i.way_id;
    tag_mem_pkt_o.state   = cmd_i.state;
    stat_mem_pkt_o.index  = cmd_index;
    stat_mem_pkt_o.way_id = cmd_i.way_id;
    data_mem_pkt_o.index  = cmd_index;
    data_mem_pkt_o.way_id = cmd_i.way_id;

    case (state_r)
      e_reset: begin
        state_n = e_clear;
      end

      // wipe every set of tag and stat mem
      e_clear: begin
        tag_mem_pkt_o.opcode  = e_tag_set_clear;
        tag_mem_pkt_o.index   = cnt_r[lg_sets_c-1:0];
        tag_mem_pkt_o.way_id  = '0;
        tag_mem_pkt_o.state   = e_coh_i;
        tag_mem_pkt_v_o       = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_set_clear;
        stat_mem_pkt_o.index  = cnt_r[lg_sets_c-1:0];
        stat_mem_pkt_o.way_id = '0;
        stat_mem_pkt_v_o      = 1'b1;
        if (tag_mem_pkt_yumi_i && stat_mem_pkt_yumi_i) begin
          if (cnt_r == sync_cnt_width_c'(sets_c-1)) begin
            cnt_clr = 1'b1;
            state_n = e_ready;
          end else begin
            cnt_inc = 1'b1;
          end
        end
      end

      // a new command starts only once the response slot is empty
      e_ready: begin
        if (cmd_v_i && !lce_resp_v_o) begin
          case (cmd_i.msg_type)
            e_cmd_sync: begin
              resp_load  = 1'b1;
              cmd_yumi_o = 1'b1;
            end
            e_cmd_set_clear: begin
              tag_mem_pkt_o.opcode  = e_tag_set_clear;
              tag_mem_pkt_v_o       = 1'b1;
              stat_mem_pkt_o.opcode = e_stat_set_clear;
              stat_mem_pkt_v_o      = 1'b1;
              cmd_yumi_o            = tag_mem_pkt_yumi_i & stat_mem_pkt_yumi_i;
            end
            e_cmd_inv: begin
              tag_mem_pkt_o.opcode = e_tag_set_state;
              tag_mem_pkt_o.state  = e_coh_i;
              tag_mem_pkt_v_o      = 1'b1;
              resp_n.msg_type      = e_resp_inv_ack;
              resp_load            = tag_mem_pkt_yumi_i;
              cmd_yumi_o           = tag_mem_pkt_yumi_i;
            end
            e_cmd_st: begin
              tag_mem_pkt_o.opcode = e_tag_set_state;
              tag_mem_pkt_v_o      = 1'b1;
              cmd_yumi_o           = tag_mem_pkt_yumi_i;
            end
            e_cmd_data: begin
              data_mem_pkt_o.opcode = e_data_write;
              data_mem_pkt_o.data   = cmd_i.data;
              data_mem_pkt_v_o      = 1'b1;
              tag_mem_pkt_o.opcode  = e_tag_set_tag;
              tag_mem_pkt_o.tag     = cmd_tag;
              tag_mem_pkt_v_o       = 1'b1;
              if (tag_mem_pkt_yumi_i && data_mem_pkt_yumi_i) begin
                state_n = e_coh_ack;
              end
            end
            e_cmd_st_wakeup: begin
              tag_mem_pkt_o.opcode = e_tag_set_state;
              tag_mem_pkt_v_o      = 1'b1;
              if (tag_mem_pkt_yumi_i) begin
                state_n = e_coh_ack;
              end
            end
            e_cmd_wb: begin
              stat_mem_pkt_o.opcode = e_stat_read;
              stat_mem_pkt_v_o      = 1'b1;
              if (stat_mem_pkt_yumi_i) begin
                state_n = e_wb;
              end
            end
            e_cmd_st_wb: begin
              tag_mem_pkt_o.opcode  = e_tag_set_state;
              tag_mem_pkt_v_o       = 1'b1;
              stat_mem_pkt_o.opcode = e_stat_read;
              stat_mem_pkt_v_o      = 1'b1;
              if (tag_mem_pkt_yumi_i && stat_mem_pkt_yumi_i) begin
                state_n = e_wb;
              end
            end
            default: begin
              // unknown opcode is dropped
              cmd_yumi_o = 1'b1;
            end
          endcase
        end
      end

      e_coh_ack: begin
        resp_n.msg_type = e_resp_coh_ack;
        resp_load       = 1'b1;
        cmd_yumi_o      = 1'b1;
        state_n         = e_ready;
      end

      // clean line answers null_wb, dirty line goes to the data read
      e_wb: begin
        if (stat_v_r) begin
          if (stat_r.dirty[cmd_i.way_id]) begin
            state_n = e_wb_dirty_rd;
          end else begin
            resp_n.msg_type = e_resp_null_wb;
            resp_load       = 1'b1;
            cmd_yumi_o      = 1'b1;
            state_n         = e_ready;
          end
        end
      end

      e_wb_dirty_rd: begin
        data_mem_pkt_o.opcode = e_data_read;
        data_mem_pkt_v_o      = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_clear_dirty;
        stat_mem_pkt_v_o      = 1'b1;
        if (data_mem_pkt_yumi_i && stat_mem_pkt_yumi_i) begin
          state_n = e_wb_dirty_send;
        end
      end

      e_wb_dirty_send: begin
        if (data_v_r) begin
          resp_n.msg_type = e_resp_wb;
          resp_n.data     = data_r;
          resp_load       = 1'b1;
          cmd_yumi_o      = 1'b1;
          state_n         = e_ready;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase

    // after clearing, the counter tracks sync acks that have left
    if (sync_fire) begin
      if (cnt_r == sync_cnt_width_c'(num_cce_c-1)) begin
        cnt_clr = 1'b1;
      end else begin
        cnt_inc = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= e_reset;
      cnt_r        <= '0;
      sync_done_o  <= 1'b0;
      lce_resp_v_o <= 1'b0;
      stat_rd_r    <= 1'b0;
      stat_v_r     <= 1'b0;
      data_rd_r    <= 1'b0;
      data_v_r     <= 1'b0;
    end else begin
      state_r <= state_n;
      if (cnt_clr) begin
        cnt_r <= '0;
      end else if (cnt_inc) begin
        cnt_r <= cnt_r + 1'b1;
      end
      if (sync_fire && cnt_r == sync_cnt_width_c'(num_cce_c-1)) begin
        sync_done_o <= 1'b1;
      end
      // response slot holds until the CCE takes it
      if (resp_load) begin
        lce_resp_v_o <= 1'b1;
      end else if (lce_resp_ready_i) begin
        lce_resp_v_o <= 1'b0;
      end
      // read data lands one cycle after yumi
      stat_rd_r <= stat_rd_fire;
      data_rd_r <= data_rd_fire;
      if (stat_rd_fire) begin
        stat_v_r <= 1'b0;
      end else if (stat_rd_r) begin
        stat_v_r <= 1'b1;
      end
      if (data_rd_fire) begin
        data_v_r <= 1'b0;
      end else if (data_rd_r) begin
        data_v_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_load) begin
      lce_resp_o <= resp_n;
    end
    if (stat_rd_r) begin
      stat_r <= stat_mem_i;
    end
    if (data_rd_r) begin
      data_r <= data_mem_i;
    end
  end

  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_resp_v_o && !lce_resp_ready_i) |=> (lce_resp_v_o && $stable(lce_resp_o)));

  // command states keep their command at the queue head
  a_state_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r inside {e_coh_ack, e_wb, e_wb_dirty_rd, e_wb_dirty_send}) |-> cmd_v_i);

endmodule

/* logic/lce_cmd.sv */
// lce command handler top: command queue feeding the command engine
`timescale 1ns/1ns

module lce_cmd
  import lce_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [lce_id_width_c-1:0]  lce_id_i,

  // commands from the CCE
  input  lce_cmd_s                   lce_cmd_i,
  input  logic                       lce_cmd_v_i,
  output logic                       lce_cmd_ready_o,

  // responses to the CCE
  output lce_resp_s                  lce_resp_o,
  output logic                       lce_resp_v_o,
  input  logic                       lce_resp_ready_i,

  output tag_mem_pkt_s               tag_mem_pkt_o,
  output logic                       tag_mem_pkt_v_o,
  input  logic                       tag_mem_pkt_yumi_i,
  output stat_mem_pkt_s              stat_mem_pkt_o,
  output logic                       stat_mem_pkt_v_o,
  input  logic                       stat_mem_pkt_yumi_i,
  input  stat_info_s                 stat_mem_i,
  output data_mem_pkt_s              data_mem_pkt_o,
  output logic                       data_mem_pkt_v_o,
  input  logic                       data_mem_pkt_yumi_i,
  input  logic [block_width_c-1:0]   data_mem_i,

  output logic                       ready_o,
  output logic                       sync_done_o,
  output logic                       cache_req_complete_o
);

  lce_cmd_s cmd;
  logic     cmd_v;
  logic     cmd_yumi;

  lce_cmd_fifo cmd_fifo0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (lce_cmd_i),
    .v_i     (lce_cmd_v_i),
    .ready_o (lce_cmd_ready_o),
    .data_o  (cmd),
    .v_o     (cmd_v),
    .yumi_i  (cmd_yumi)
  );

  lce_cmd_engine engine0 (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_id_i             (lce_id_i),
    .cmd_i                (cmd),
    .cmd_v_i              (cmd_v),
    .cmd_yumi_o           (cmd_yumi),
    .lce_resp_o           (lce_resp_o),
    .lce_resp_v_o         (lce_resp_v_o),
    .lce_resp_ready_i     (lce_resp_ready_i),
    .tag_mem_pkt_o        (tag_mem_pkt_o),
    .tag_mem_pkt_v_o      (tag_mem_pkt_v_o),
    .tag_mem_pkt_yumi_i   (tag_mem_pkt_yumi_i),
    .stat_mem_pkt_o       (stat_mem_pkt_o),
    .stat_mem_pkt_v_o     (stat_mem_pkt_v_o),
    .stat_mem_pkt_yumi_i  (stat_mem_pkt_yumi_i),
    .stat_mem_i           (stat_mem_i),
    .data_mem_pkt_o       (data_mem_pkt_o),
    .data_mem_pkt_v_o     (data_mem_pkt_v_o),
    .data_mem_pkt_yumi_i  (data_mem_pkt_yumi_i),
    .data_mem_i           (data_mem_i),
    .ready_o              (ready_o),
    .sync_done_o          (sync_done_o),
    .cache_req_complete_o (cache_req_complete_o)
  );

endmodule

/* logic/lce_cmd_fifo.sv */
// two-entry command queue, valid/ready in and valid/yumi out
`timescale 1ns/1ns

module lce_cmd_fifo
  import lce_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,

  input  lce_cmd_s data_i,
  input  logic     v_i,
  output logic     ready_o,

  output lce_cmd_s data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  lce_cmd_s mem_r [2];
  logic     wptr_r;
  logic     rptr_r;
  logic     full_r;
  logic     empty_r;
  logic     enq;
  logic     deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  // storage, no reset needed
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq) begin
        wptr_r <= ~wptr_r;
      end
      if (deq) begin
        rptr_r <= ~rptr_r;
      end
      // occupancy only changes when exactly one side moves
      if (enq && !deq) begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end else if (deq && !enq) begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

  a_no_yumi_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> !empty_r);

  // an accepted write never lands on the unread head
  a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_i && ready_o) |-> (empty_r || (wptr_r != rptr_r)));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the lce command handler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f lce_cmd.f --top-module lce_cmd_tb -o lce_cmd_sim

./obj_dir/lce_cmd_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi

/* testbench/lce_cmd_tests.svh */
// directed test tasks and value checks for the lce command handler
task automatic check(string name, logic [127:0] exp, logic [127:0] act);
  assert (exp === act) else begin
    errors++;
    $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, act);
  end
endtask

function automatic logic [paddr_width_c-1:0] make_addr(int tag, int index);
  return {tag_width_c'(tag), lg_sets_c'(index), block_offset_c'(0)};
endfunction

task automatic send_cmd(lce_cmd_type_e t, logic [15:0] addr, int src, int way,
                        coh_state_e st, logic [63:0] data);
  @(negedge clk);
  cmd = '{msg_type: t, addr: addr, src_id: 2'(src), way_id: 1'(way), state: st, data: data};
  cmd_v = 1'b1;
  do @(posedge clk); while (!cmd_ready);
  @(negedge clk);
  cmd_v = 1'b0;
endtask

task automatic expect_resp(lce_resp_type_e t, logic [15:0] addr, int dst, logic [63:0] data);
  lce_resp_s r;
  logic done;
  while (resp_log.size() == 0) @(negedge clk);
  r = resp_log.pop_front();
  done = done_log.pop_front();
  check("lce_resp_o.msg_type", 128'(t), 128'(r.msg_type));
  check("lce_resp_o.addr", 128'(addr), 128'(r.addr));
  check("lce_resp_o.dst_id", 128'(dst), 128'(r.dst_id));
  check("lce_resp_o.src_id", 128'(lce_id), 128'(r.src_id));
  check("cache_req_complete_o", 128'(t == e_resp_coh_ack), 128'(done));
  if (t == e_resp_wb) check("lce_resp_o.data", 128'(data), 128'(r.data));
endtask

task automatic test_init();
  check("outputs after reset", 128'd0,
        128'({eng_ready, sync_done, resp_v, tag_v, stat_v, data_v, complete}));
  while (!eng_ready) @(negedge clk);
  check("tag clear count", 128'd8, 128'(tag_log.size()));
  check("stat clear count", 128'd8, 128'(stat_log.size()));
  for (int i = 0; i < 8 && i < tag_log.size() && i < stat_log.size(); i++) begin
    check("tag_mem_pkt_o.index", 128'(i), 128'(tag_log[i].index));
    check("tag_mem_pkt_o.opcode", 128'(e_tag_set_clear), 128'(tag_log[i].opcode));
    check("stat_mem_pkt_o.index", 128'(i), 128'(stat_log[i].index));
    check("stat_mem_pkt_o.opcode", 128'(e_stat_set_clear), 128'(stat_log[i].opcode));
  end
  tag_log.delete();
  stat_log.delete();
endtask

task automatic test_sync();
  send_cmd(e_cmd_sync, '0, 0, 0, e_coh_i, '0);
  expect_resp(e_resp_sync_ack, '0, 0, '0);
  @(negedge clk);
  check("sync_done_o", 128'd0, 128'(sync_done));
  send_cmd(e_cmd_sync, '0, 3, 0, e_coh_i, '0);
  expect_resp(e_resp_sync_ack, '0, 3, '0);
  @(negedge clk);
  check("sync_done_o", 128'd1, 128'(sync_done));
endtask

task automatic test_inv_clear_state();
  send_cmd(e_cmd_inv, make_addr(12'h2a, 5), 2, 1, e_coh_m, '0);
  expect_resp(e_resp_inv_ack, make_addr(12'h2a, 5), 2, '0);
  check("tag_mem_pkt_o", 128'({e_tag_set_state, 3'd5, 1'b1, e_coh_i}),
        128'({tag_log[0].opcode, tag_log[0].index, tag_log[0].way_id, tag_log[0].state}));
  tag_log.delete();
  send_cmd(e_cmd_set_clear, make_addr(3, 6), 1, 0, e_coh_i, '0);
  while (stat_log.size() == 0) @(negedge clk);
  check("stat_mem_pkt_o.opcode", 128'(e_stat_set_clear), 128'(stat_log[0].opcode));
  check("stat_mem_pkt_o.index", 128'd6, 128'(stat_log[0].index));
  send_cmd(e_cmd_st, make_addr(7, 2), 1, 1, e_coh_s, '0);
  while (tag_log.size() < 2) @(negedge clk);
  check("tag_mem_pkt_o.opcode", 128'(e_tag_set_state), 128'(tag_log[1].opcode));
  check("tag_mem_pkt_o.state", 128'(e_coh_s), 128'(tag_log[1].state));
  repeat (5) @(negedge clk);
  check("response count", 128'd0, 128'(resp_log.size()));
  tag_log.delete();
  stat_log.delete();
endtask

task automatic test_fill();
  stall_on = 1'b0;
  send_cmd(e_cmd_data, make_addr(10'h155, 3), 0, 1, e_coh_e, 64'hfeed_0123_4567_beef);
  expect_resp(e_resp_coh_ack, make_addr(10'h155, 3), 0, '0);
  check("data_mem_pkt_o.data", 128'(64'hfeed_0123_4567_beef), 128'(data_log[0].data));
  check("tag_mem_pkt_o.tag", 128'(10'h155), 128'(tag_log[0].tag));
  check("cache_req_complete_o pulses", 128'd1, 128'(complete_cnt));
  send_cmd(e_cmd_st_wakeup, make_addr(4, 1), 3, 0, e_coh_s, '0);
  expect_resp(e_resp_coh_ack, make_addr(4, 1), 3, '0);
  repeat (2) @(negedge clk);
  check("cache_req_complete_o pulses", 128'd2, 128'(complete_cnt));
  stall_on = 1'b1;
  data_log.delete();
  tag_log.delete();
endtask

task automatic test_writeback();
  dirty_arr[4][0] = 1'b0;
  send_cmd(e_cmd_wb, make_addr(9, 4), 1, 0, e_coh_i, '0);
  expect_resp(e_resp_null_wb, make_addr(9, 4), 1, '0);
  dirty_arr[2][1] = 1'b1;
  data_arr[2][1] = 64'h0bad_cafe_1357_9bdf;
  send_cmd(e_cmd_st_wb, make_addr(9, 2), 2, 1, e_coh_s, '0);
  expect_resp(e_resp_wb, make_addr(9, 2), 2, 64'h0bad_cafe_1357_9bdf);
  check("dirty bit", 128'd0, 128'(dirty_arr[2][1]));
  check("data_mem_pkt_o", 128'({e_data_read, 3'd2, 1'b1}),
        128'({data_log[0].opcode, data_log[0].index, data_log[0].way_id}));
  check("stat_mem_pkt_o", 128'({e_stat_clear_dirty, 3'd2, 1'b1}),
        128'({stat_log[2].opcode, stat_log[2].index, stat_log[2].way_id}));
  check("tag_mem_pkt_o.state", 128'(e_coh_s), 128'(tag_log[0].state));
endtask

task automatic test_backpressure();
  resp_ready = 1'b0;
  for (int i = 0; i < 3; i++) send_cmd(e_cmd_inv, make_addr(i + 20, i), 1, 0, e_coh_i, '0);
  repeat (20) @(negedge clk);
  check("lce_cmd_ready_o", 128'd0, 128'(cmd_ready));
  resp_ready = 1'b1;
  send_cmd(e_cmd_inv, make_addr(23, 3), 1, 0, e_coh_i, '0);
  for (int i = 0; i < 4; i++) expect_resp(e_resp_inv_ack, make_addr(i + 20, i), 1, '0);
endtask

/* testbench/lce_cmd_tb.sv */
// lce command handler testbench: clock, reset, dut0, cache memory model, timeout and report
`timescale 1ns/1ns

module lce_cmd_tb;
  import lce_pkg::*;

  localparam int max_cycles_c = 4000;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic [lce_id_width_c-1:0] lce_id = 2'd1;
  lce_cmd_s cmd = '0;
  logic cmd_v = 1'b0;
  logic cmd_ready;
  lce_resp_s resp;
  logic resp_v;
  logic resp_ready = 1'b1;
  tag_mem_pkt_s tag_pkt;
  logic tag_v;
  logic tag_yumi = 1'b0;
  stat_mem_pkt_s stat_pkt;
  logic stat_v;
  logic stat_yumi = 1'b0;
  stat_info_s stat_rd = '0;
  data_mem_pkt_s data_pkt;
  logic data_v;
  logic data_yumi = 1'b0;
  logic [block_width_c-1:0] data_rd = '0;
  logic eng_ready;
  logic sync_done;
  logic complete;

  int errors = 0;
  int cycles = 0;
  int complete_cnt = 0;
  logic stall_on = 1'b1;
  logic [31:0] lcg_r = 32'h111f_1e9e;

  // cache model contents and accepted packets
  logic [assoc_c-1:0] dirty_arr [sets_c];
  logic [block_width_c-1:0] data_arr [sets_c][assoc_c];
  tag_mem_pkt_s tag_log[$];
  stat_mem_pkt_s stat_log[$];
  data_mem_pkt_s data_log[$];
  lce_resp_s resp_log[$];
  logic done_log[$];
  lce_resp_s prev_resp;
  logic hold_r = 1'b0;

  lce_cmd dut0 (
    .clk_i(clk), .reset_i(reset), .lce_id_i(lce_id),
    .lce_cmd_i(cmd), .lce_cmd_v_i(cmd_v), .lce_cmd_ready_o(cmd_ready),
    .lce_resp_o(resp), .lce_resp_v_o(resp_v), .lce_resp_ready_i(resp_ready),
    .tag_mem_pkt_o(tag_pkt), .tag_mem_pkt_v_o(tag_v), .tag_mem_pkt_yumi_i(tag_yumi),
    .stat_mem_pkt_o(stat_pkt), .stat_mem_pkt_v_o(stat_v), .stat_mem_pkt_yumi_i(stat_yumi),
    .stat_mem_i(stat_rd),
    .data_mem_pkt_o(data_pkt), .data_mem_pkt_v_o(data_v), .data_mem_pkt_yumi_i(data_yumi),
    .data_mem_i(data_rd),
    .ready_o(eng_ready), .sync_done_o(sync_done), .cache_req_complete_o(complete)
  );

  always #50 clk = ~clk;

  function automatic logic lcg_bit();
    lcg_r = lcg_r * 32'd1664525 + 32'd1013904223;
    return lcg_r[16];
  endfunction

  // yumi choices change on the falling edge, one choice for all memories
  always @(negedge clk) begin
    logic accept;
    accept = stall_on ? lcg_bit() : 1'b1;
    tag_yumi  <= accept;
    stat_yumi <= accept;
    data_yumi <= accept;
  end

  // memory model and response monitor, sampling pre-edge values
  always @(posedge clk) begin
    if (!reset) begin
      if (tag_v && tag_yumi) tag_log.push_back(tag_pkt);
      if (stat_v && stat_yumi) begin
        stat_log.push_back(stat_pkt);
        case (stat_pkt.opcode)
          e_stat_set_clear: dirty_arr[stat_pkt.index] <= '0;
          e_stat_read: stat_rd <= '{dirty: dirty_arr[stat_pkt.index]};
          e_stat_clear_dirty: dirty_arr[stat_pkt.index][stat_pkt.way_id] <= 1'b0;
          default: ;
        endcase
      end
      if (data_v && data_yumi) begin
        data_log.push_back(data_pkt);
        if (data_pkt.opcode == e_data_write) begin
          data_arr[data_pkt.index][data_pkt.way_id] <= data_pkt.data;
        end else begin
          data_rd <= data_arr[data_pkt.index][data_pkt.way_id];
        end
      end
      if (hold_r) check("lce_resp_o", 128'(prev_resp), 128'(resp));
      if (hold_r) check("lce_resp_v_o", 128'd1, 128'(resp_v));
      hold_r <= resp_v && !resp_ready;
      prev_resp <= resp;
      // completion flag travels with each response that leaves
      if (resp_v && resp_ready) begin
        resp_log.push_back(resp);
        done_log.push_back(complete);
      end
      if (complete) begin
        complete_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles_c) begin
      $display("run stopped after %0d cycles without finishing the tests", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  `include "lce_cmd_tests.svh"

  initial begin
    for (int s = 0; s < sets_c; s++) begin
      dirty_arr[s] = '1;
      for (int w = 0; w < assoc_c; w++) data_arr[s][w] = {16'(s * 3 + w), 48'h5a5a_0000_c3c3};
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;
    test_init();
    test_sync();
    test_inv_clear_state();
    test_fill();
    test_writeback();
    test_backpressure();
    repeat (5) @(negedge clk);
    check("cache_req_complete_o pulses", 128'd2, 128'(complete_cnt));
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
